// File: bench/icache_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module icache_mem_model (
    input  logic                 clk,
    input  logic                 reset,
    input  icache_pkg::axi_ar_t  ar,
    output logic                 ar_ready,
    output icache_pkg::axi_r_t   r,
    input  logic                 r_ready
);

    logic [31:0] lfsr;
    logic [31:0] burst_addr;
    logic busy;
    logic reset_s;
    logic ar_valid_s;
    logic ar_hs;
    logic r_hs;
    icache_pkg::icache_addr_t ar_addr_s;
    int beat;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // Gap when two fresh bits are both set, about one cycle in four
    task automatic drive_beat();
        logic b0;
        logic b1;
        lfsr = lfsr_next(lfsr);
        b0 = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b1 = lfsr[0];
        r.valid = !(b0 && b1);
        r.data = (burst_addr + 32'(beat * 4)) ^ 32'h5A5A_0000;
        r.last = (beat == icache_pkg::BLOCK_WORDS - 1);
    endtask

    initial begin
        lfsr = 32'd86745;
        burst_addr = '0;
        busy = 1'b0;
        beat = 0;
        ar_ready = 1'b0;
        r = '0;
        forever begin
            @(negedge clk);
            reset_s = reset;
            ar_valid_s = ar.valid;
            ar_hs = ar.valid && ar_ready;
            r_hs = r.valid && r_ready;
            ar_addr_s = ar.addr;
            @(posedge clk);
            #1;
            if (reset_s) begin
                busy = 1'b0;
                ar_ready = 1'b0;
                r = '0;
            end else if (!busy) begin
                if (ar_hs) begin
                    busy = 1'b1;
                    ar_ready = 1'b0;
                    burst_addr = ar_addr_s.word;
                    beat = 0;
                    drive_beat();
                end else begin
                    // Address taken one cycle after it shows up
                    ar_ready = ar_valid_s;
                end
            end else if (r_hs) begin
                if (r.last) begin
                    busy = 1'b0;
                    r = '0;
                end else begin
                    beat++;
                    drive_beat();
                end
            end else if (!r.valid) begin
                drive_beat();
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/icache_props.sv
`timescale 1ns/1ns
`default_nettype none

module icache_props (
    input logic                     clk,
    input logic                     reset,
    input icache_pkg::fetch_req_t   req,
    input icache_pkg::fetch_rsp_t   rsp,
    input icache_pkg::axi_ar_t      ar,
    input logic                     ar_ready,
    input icache_pkg::ctrl_state_t  state
);

    logic pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (req.valid) begin
            pending <= 1'b1;
        end else if (rsp.ready) begin
            pending <= 1'b0;
        end
    end

    ready_needs_request: assert property (@(posedge clk) disable iff (reset)
        rsp.ready |-> pending)
        else $error("fetch ready without an outstanding request");

    ready_single_pulse: assert property (@(posedge clk) disable iff (reset)
        rsp.ready |=> !rsp.ready)
        else $error("fetch ready held for more than one cycle");

    ar_held_until_ready: assert property (@(posedge clk) disable iff (reset)
        ar.valid && !ar_ready |=> ar.valid)
        else $error("ar valid dropped before ar_ready");

    // A hit answers at once, a miss puts the burst address out instead
    hit_in_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (state == icache_pkg::CTRL_IDLE) && req.valid |=> (rsp.ready != ar.valid))
        else $error("neither a hit answer nor ar valid one cycle after the request");

endmodule

bind icache_top icache_props props0 (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .rsp      (rsp),
    .ar       (ar),
    .ar_ready (ar_ready),
    .state    (ctrl_state)
);

`default_nettype wire

// File: bench/icache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tb;

    typedef struct packed {
        logic [31:0] pc;
        logic refill;
        logic reset_first;
    } stim_t;

    logic clk;
    logic reset;
    icache_pkg::fetch_req_t req;
    icache_pkg::fetch_rsp_t rsp;
    icache_pkg::axi_ar_t ar;
    logic ar_ready;
    icache_pkg::axi_r_t r;
    logic r_ready;

    int cycle_count = 0;
    int ar_count = 0;
    int beat_count = 0;
    logic last_beat_seen = 1'b0;
    icache_pkg::axi_ar_t last_ar = '0;

    // Line at index 3 is fought over by tags 0x10, 0x20 and 0x12
    stim_t stim [16] = '{
        '{32'h0000_1034, 1'b1, 1'b0},
        '{32'h0000_1030, 1'b0, 1'b0},
        '{32'h0000_1038, 1'b0, 1'b0},
        '{32'h0000_103C, 1'b0, 1'b0},
        '{32'h0000_1034, 1'b0, 1'b0},
        '{32'h0000_2038, 1'b1, 1'b0},
        '{32'h0000_1034, 1'b1, 1'b0},
        '{32'h0000_2030, 1'b1, 1'b0},
        '{32'h0000_00F0, 1'b1, 1'b0},
        '{32'h0000_00F4, 1'b0, 1'b0},
        '{32'h0000_5A50, 1'b1, 1'b0},
        '{32'h0000_5A5C, 1'b0, 1'b0},
        '{32'h0000_5A5C, 1'b1, 1'b1},
        '{32'h0000_00F0, 1'b1, 1'b0},
        '{32'h0000_00F8, 1'b0, 1'b0},
        '{32'h0000_1234, 1'b1, 1'b0}
    };

    icache_top dut0 (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .rsp      (rsp),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r        (r),
        .r_ready  (r_ready)
    );

    icache_mem_model mem0 (
        .clk      (clk),
        .reset    (reset),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r        (r),
        .r_ready  (r_ready)
    );

    always #2 clk = ~clk;

    // Memory rule: a word is its own address XOR 0x5A5A0000
    function automatic icache_pkg::icache_word_t expected_word(input logic [31:0] pc);
        return {pc[31:2], 2'b00} ^ 32'h5A5A_0000;
    endfunction

    function automatic icache_pkg::icache_addr_t line_address(input logic [31:0] pc);
        icache_pkg::icache_addr_t a;
        a.word = {pc[31:4], 4'b0000};
        return a;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input icache_pkg::icache_word_t got,
                              input icache_pkg::icache_word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input icache_pkg::icache_addr_t got,
                              input icache_pkg::icache_addr_t exp);
        if (got.word !== exp.word) begin
            report_failure($sformatf("ERR %s: got %h, expected %h", name, got.word, exp.word));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("ERR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // Bus activity, sampled between edges where it is stable
    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count > $size(stim) * 40) begin
            report_failure("Timeout: the run did not finish within the cycle limit");
        end
        if (last_beat_seen) begin
            check_flag("rsp.ready", rsp.ready, 1'b1);
        end
        last_beat_seen = r.valid && r_ready && r.last;
        if (ar.valid && ar_ready) begin
            ar_count++;
            last_ar = ar;
        end
        if (r.valid && r_ready) begin
            beat_count++;
        end
    end

    task automatic check_quiet();
        repeat (4) begin
            @(negedge clk);
            check_flag("rsp.ready", rsp.ready, 1'b0);
            check_flag("ar.valid", ar.valid, 1'b0);
            check_flag("r_ready", r_ready, 1'b0);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        check_quiet();
    endtask

    task automatic fetch(input logic [31:0] pc, output icache_pkg::icache_word_t word,
                         output int latency);
        @(posedge clk);
        #1;
        req.valid = 1'b1;
        req.addr.word = pc;
        @(posedge clk);
        #1;
        req.valid = 1'b0;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
        end while (!rsp.ready);
        word = rsp.word;
        #1;
    endtask

    initial begin
        icache_pkg::icache_word_t word;
        int latency;
        int ar_before;
        int beats_before;
        int i;
        clk = 1'b0;
        reset = 1'b1;
        req = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        check_quiet();
        for (i = 0; i < $size(stim); i++) begin
            if (stim[i].reset_first) begin
                apply_reset();
            end
            ar_before = ar_count;
            beats_before = beat_count;
            fetch(stim[i].pc, word, latency);
            check_word("rsp.word", word, expected_word(stim[i].pc));
            if (stim[i].refill) begin
                check_count("ar handshakes", ar_count - ar_before, 1);
                check_count("r beats", beat_count - beats_before, icache_pkg::BLOCK_WORDS);
                check_addr("ar.addr", last_ar.addr, line_address(stim[i].pc));
                check_count("ar.len", int'(last_ar.len), icache_pkg::BLOCK_WORDS - 1);
                check_count("ar.burst", int'(last_ar.burst), 1);
            end else begin
                check_count("ar handshakes", ar_count - ar_before, 0);
                check_count("r beats", beat_count - beats_before, 0);
                check_count("hit latency", latency, 1);
            end
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
source/icache_pkg.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_refill.sv
source/icache_ctrl.sv
source/icache_top.sv
bench/icache_mem_model.sv
bench/icache_props.sv
bench/icache_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module icache_tb -o icache_sim &&
./obj_dir/icache_sim || exit 1

// File: source/icache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  icache_pkg::fetch_req_t    req,
    input  logic                      hit,
    input  icache_pkg::icache_word_t  rd_word,
    input  logic                      refill_done,
    output icache_pkg::fetch_rsp_t    rsp,
    output icache_pkg::icache_addr_t  lookup_addr,
    output logic                      refill_start,
    output logic                      tag_write,
    output icache_pkg::ctrl_state_t   state
);

    icache_pkg::ctrl_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= icache_pkg::CTRL_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // PC is held for the whole lookup and refill
    always_ff @(posedge clk) begin
        if (state == icache_pkg::CTRL_IDLE && req.valid) begin
            lookup_addr <= req.addr;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::CTRL_IDLE: begin
                if (req.valid) begin
                    next_state = icache_pkg::CTRL_LOOKUP;
                end
            end
            icache_pkg::CTRL_LOOKUP: begin
                if (hit) begin
                    next_state = icache_pkg::CTRL_IDLE;
                end else begin
                    next_state = icache_pkg::CTRL_REFILL;
                end
            end
            icache_pkg::CTRL_REFILL: begin
                // Last beat lands in the data array on this edge
                if (refill_done) begin
                    next_state = icache_pkg::CTRL_RESPOND;
                end
            end
            icache_pkg::CTRL_RESPOND: begin
                next_state = icache_pkg::CTRL_IDLE;
            end
            default: begin
                next_state = icache_pkg::CTRL_IDLE;
            end
        endcase
    end

    // Miss kicks off the burst in the lookup cycle itself
    assign refill_start = (state == icache_pkg::CTRL_LOOKUP) && !hit;
    assign tag_write = (state == icache_pkg::CTRL_REFILL) && refill_done;

    // Answer straight from the arrays, either on a hit or from the new line
    assign rsp.ready = ((state == icache_pkg::CTRL_LOOKUP) && hit) ||
                       (state == icache_pkg::CTRL_RESPOND);
    assign rsp.word = rd_word;

endmodule

`default_nettype wire

// File: source/icache_data_array.sv
`timescale 1ns/1ns
`default_nettype none

module icache_data_array (
    input  logic                        clk,
    input  icache_pkg::icache_addr_t    addr,
    input  logic                        beat_write,
    input  icache_pkg::icache_offset_t  beat_index,
    input  icache_pkg::icache_word_t    beat_word,
    output icache_pkg::icache_word_t    rd_word
);

    icache_pkg::icache_word_t lines [icache_pkg::LINES][icache_pkg::BLOCK_WORDS];

    // One word per refill beat, into the line being looked up
    always_ff @(posedge clk) begin
        if (beat_write) begin
            lines[addr.fields.index][beat_index] <= beat_word;
        end
    end

    assign rd_word = lines[addr.fields.index][addr.fields.offset];

endmodule

`default_nettype wire

// File: source/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // Cache geometry
    localparam int BLOCK_WORDS = 4;
    localparam int OFFSET_WIDTH = 2;
    localparam int INDEX_WIDTH = 4;
    localparam int TAG_WIDTH = 32 - 2 - OFFSET_WIDTH - INDEX_WIDTH;
    localparam int LINES = 1 << INDEX_WIDTH;

    // Byte bits of one cache line, cleared to get the burst start address
    localparam logic [31:0] LINE_MASK = 32'(BLOCK_WORDS * 4 - 1);

    // AXI read burst encoding
    localparam logic [7:0] BURST_LEN = 8'(BLOCK_WORDS - 1);
    localparam logic [1:0] BURST_INCR = 2'b01;

    typedef logic [31:0] icache_word_t;
    typedef logic [OFFSET_WIDTH-1:0] icache_offset_t;

    // PC split as the cache sees it
    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        logic [INDEX_WIDTH-1:0] index;
        icache_offset_t offset;
        logic [1:0] byte_offset;
    } icache_addr_fields_t;

    typedef union packed {
        logic [31:0] word;
        icache_addr_fields_t fields;
    } icache_addr_t;

    // Fetch unit strobes
    typedef struct packed {
        logic valid;
        icache_addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic ready;
        icache_word_t word;
    } fetch_rsp_t;

    // AXI read address and read data channels
    typedef struct packed {
        logic valid;
        icache_addr_t addr;
        logic [7:0] len;
        logic [1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        logic valid;
        icache_word_t data;
        logic last;
    } axi_r_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LOOKUP,
        CTRL_REFILL,
        CTRL_RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/icache_refill.sv
`timescale 1ns/1ns
`default_nettype none

module icache_refill (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  icache_pkg::icache_addr_t    line_addr,
    input  logic                        ar_ready,
    input  icache_pkg::axi_r_t          r,
    output icache_pkg::axi_ar_t         ar,
    output logic                        r_ready,
    output logic                        beat_write,
    output icache_pkg::icache_offset_t  beat_index,
    output icache_pkg::icache_word_t    beat_word,
    output logic                        done
);

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_ADDR,
        RF_DATA
    } refill_state_t;

    refill_state_t rf_state;
    icache_pkg::icache_offset_t beat_count;
    icache_pkg::icache_addr_t aligned_addr;

    // Burst starts at word 0 of the line
    assign aligned_addr.word = line_addr.word & ~icache_pkg::LINE_MASK;

    always_ff @(posedge clk) begin
        if (reset) begin
            rf_state <= RF_IDLE;
            beat_count <= '0;
        end else begin
            case (rf_state)
                RF_IDLE: begin
                    if (start) begin
                        beat_count <= '0;
                        if (ar_ready) begin
                            rf_state <= RF_DATA;
                        end else begin
                            rf_state <= RF_ADDR;
                        end
                    end
                end
                RF_ADDR: begin
                    if (ar_ready) begin
                        rf_state <= RF_DATA;
                    end
                end
                RF_DATA: begin
                    if (beat_write) begin
                        beat_count <= beat_count + icache_pkg::icache_offset_t'(1);
                        if (r.last) begin
                            rf_state <= RF_IDLE;
                        end
                    end
                end
                default: begin
                    rf_state <= RF_IDLE;
                end
            endcase
        end
    end

    // Address goes out in the start cycle and holds until accepted
    assign ar.valid = ((rf_state == RF_IDLE) && start) || (rf_state == RF_ADDR);
    assign ar.addr = aligned_addr;
    assign ar.len = icache_pkg::BURST_LEN;
    assign ar.burst = icache_pkg::BURST_INCR;

    assign r_ready = (rf_state == RF_DATA);
    assign beat_write = r_ready && r.valid;
    assign beat_index = beat_count;
    assign beat_word = r.data;
    assign done = beat_write && r.last;

endmodule

`default_nettype wire

// File: source/icache_tag_array.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tag_array (
    input  logic                      clk,
    input  logic                      reset,
    input  icache_pkg::icache_addr_t  addr,
    input  logic                      tag_write,
    output logic                      hit
);

    logic [icache_pkg::LINES-1:0] valid_bits;
    logic [icache_pkg::TAG_WIDTH-1:0] tags [icache_pkg::LINES];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (tag_write) begin
            valid_bits[addr.fields.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_write) begin
            tags[addr.fields.index] <= addr.fields.tag;
        end
    end

    // Compare in the same cycle as the read
    assign hit = valid_bits[addr.fields.index] &&
                 (tags[addr.fields.index] == addr.fields.tag);

endmodule

`default_nettype wire

// File: source/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

module icache_top (
    input  logic                    clk,
    input  logic                    reset,
    input  icache_pkg::fetch_req_t  req,
    output icache_pkg::fetch_rsp_t  rsp,
    output icache_pkg::axi_ar_t     ar,
    input  logic                    ar_ready,
    input  icache_pkg::axi_r_t      r,
    output logic                    r_ready
);

    icache_pkg::icache_addr_t lookup_addr;
    icache_pkg::icache_word_t rd_word;
    icache_pkg::ctrl_state_t ctrl_state;
    logic hit;
    logic tag_write;
    logic refill_start;
    logic refill_done;

    // Refill beat path into the data array
    logic beat_write;
    icache_pkg::icache_offset_t beat_index;
    icache_pkg::icache_word_t beat_word;

    icache_ctrl ctrl0 (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .hit          (hit),
        .rd_word      (rd_word),
        .refill_done  (refill_done),
        .rsp          (rsp),
        .lookup_addr  (lookup_addr),
        .refill_start (refill_start),
        .tag_write    (tag_write),
        .state        (ctrl_state)
    );

    icache_tag_array tags0 (
        .clk       (clk),
        .reset     (reset),
        .addr      (lookup_addr),
        .tag_write (tag_write),
        .hit       (hit)
    );

    icache_data_array data0 (
        .clk        (clk),
        .addr       (lookup_addr),
        .beat_write (beat_write),
        .beat_index (beat_index),
        .beat_word  (beat_word),
        .rd_word    (rd_word)
    );

    icache_refill refill0 (
        .clk        (clk),
        .reset      (reset),
        .start      (refill_start),
        .line_addr  (lookup_addr),
        .ar_ready   (ar_ready),
        .r          (r),
        .ar         (ar),
        .r_ready    (r_ready),
        .beat_write (beat_write),
        .beat_index (beat_index),
        .beat_word  (beat_word),
        .done       (refill_done)
    );

endmodule

`default_nettype wire
